/* Bender.yml */
package:
  name: fdtd_mem_ctrl

sources:
  - rtl/fdtd_pkg.sv
  - rtl/fdtd_rd_engine.sv
  - rtl/fdtd_sweep_seq.sv
  - rtl/fdtd_wr_engine.sv
  - rtl/fdtd_mem_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_fdtd_mem_ctrl.sv

/* rtl/fdtd_mem_ctrl.sv */
`timescale 1ns/1ps

module fdtd_mem_ctrl
    import fdtd_pkg::*;
#(
    parameter int BLOCK_WORDS     = 16,
    parameter int MAX_OUTSTANDING = 4
)
(
    input  logic              ACLK,
    input  logic              ARESETn,

    // control
    input  logic              start_i,
    input  logic              field_sel_i,
    input  logic [SIZE_W-1:0] size_i,
    input  fdtd_addr_u        hy_addr_i,
    input  fdtd_addr_u        ez_addr_i,
    input  logic              ctrl_int_en_i,
    input  logic              cmd_clr_int_i,

    // memory read port
    output logic              rd_req_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  logic              rd_gnt_i,
    input  logic              rd_valid_i,
    input  logic [DATA_W-1:0] rd_data_i,

    // memory write port
    output logic              wr_req_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [DATA_W-1:0] wr_data_o,
    input  logic              wr_gnt_i,

    // update engine
    output logic [DATA_W-1:0] hy_old_o,
    output logic [DATA_W-1:0] ez_old_o,
    output logic              hy_old_valid_o,
    output logic              ez_old_valid_o,
    output logic              calc_start_o,
    input  logic              calc_done_i,
    input  logic [DATA_W-1:0] new_word_i,
    output logic              new_pop_o,

    output logic              busy_o,
    output logic              int_pending_o,
    output logic              int_o
);

    logic              rd_start;
    fdtd_word_t        rd_base;
    logic [SIZE_W-1:0] rd_count;
    logic              rd_is_ez;
    logic              rd_done;
    logic              wr_start;
    fdtd_word_t        wr_base;
    logic [SIZE_W-1:0] wr_count;
    logic              wr_done;

    fdtd_rd_engine #(
        .BLOCK_WORDS     ( BLOCK_WORDS     ),
        .MAX_OUTSTANDING ( MAX_OUTSTANDING )
    ) u_rd_engine (
        .ACLK           ( ACLK           ),
        .ARESETn        ( ARESETn        ),
        .rd_start_i     ( rd_start       ),
        .rd_base_i      ( rd_base        ),
        .rd_count_i     ( rd_count       ),
        .rd_is_ez_i     ( rd_is_ez       ),
        .rd_done_o      ( rd_done        ),
        .rd_req_o       ( rd_req_o       ),
        .rd_addr_o      ( rd_addr_o      ),
        .rd_gnt_i       ( rd_gnt_i       ),
        .rd_valid_i     ( rd_valid_i     ),
        .rd_data_i      ( rd_data_i      ),
        .hy_old_o       ( hy_old_o       ),
        .hy_old_valid_o ( hy_old_valid_o ),
        .ez_old_o       ( ez_old_o       ),
        .ez_old_valid_o ( ez_old_valid_o )
    );

    fdtd_sweep_seq #(
        .BLOCK_WORDS ( BLOCK_WORDS )
    ) u_sweep_seq (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .start_i       ( start_i       ),
        .field_sel_i   ( field_sel_i   ),
        .size_i        ( size_i        ),
        .hy_addr_i     ( hy_addr_i     ),
        .ez_addr_i     ( ez_addr_i     ),
        .ctrl_int_en_i ( ctrl_int_en_i ),
        .cmd_clr_int_i ( cmd_clr_int_i ),
        .rd_start_o    ( rd_start      ),
        .rd_base_o     ( rd_base       ),
        .rd_count_o    ( rd_count      ),
        .rd_is_ez_o    ( rd_is_ez      ),
        .rd_done_i     ( rd_done       ),
        .calc_start_o  ( calc_start_o  ),
        .calc_done_i   ( calc_done_i   ),
        .wr_start_o    ( wr_start      ),
        .wr_base_o     ( wr_base       ),
        .wr_count_o    ( wr_count      ),
        .wr_done_i     ( wr_done       ),
        .busy_o        ( busy_o        ),
        .int_pending_o ( int_pending_o ),
        .int_o         ( int_o         )
    );

    fdtd_wr_engine #(
        .BLOCK_WORDS ( BLOCK_WORDS )
    ) u_wr_engine (
        .ACLK       ( ACLK       ),
        .ARESETn    ( ARESETn    ),
        .wr_start_i ( wr_start   ),
        .wr_base_i  ( wr_base    ),
        .wr_count_i ( wr_count   ),
        .wr_done_o  ( wr_done    ),
        .wr_req_o   ( wr_req_o   ),
        .wr_addr_o  ( wr_addr_o  ),
        .wr_data_o  ( wr_data_o  ),
        .wr_gnt_i   ( wr_gnt_i   ),
        .new_word_i ( new_word_i ),
        .new_pop_o  ( new_pop_o  )
    );

endmodule

/* rtl/fdtd_pkg.sv */
package fdtd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SIZE_W = 16;

    // word index, byte address without the low two bits
    typedef logic [ADDR_W-3:0] fdtd_word_t;

    typedef struct packed {
        fdtd_word_t word;
        logic [1:0] byte_off;
    } fdtd_addr_fields_t;

    // one address word, seen raw or split into word index and byte offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        fdtd_addr_fields_t fld;
    } fdtd_addr_u;

    ////////////////////////////////////////////////////////////////////////////
    // sweep sequencer states
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        READ_HY,
        READ_EZ,
        CALC,
        WAIT_CALC,
        WRITE,
        NEXT
    } fdtd_state_e;

endpackage

/* rtl/fdtd_rd_engine.sv */
`timescale 1ns/1ps

module fdtd_rd_engine
    import fdtd_pkg::*;
#(
    parameter int BLOCK_WORDS     = 16,
    parameter int MAX_OUTSTANDING = 4
)
(
    input  logic              ACLK,
    input  logic              ARESETn,

    input  logic              rd_start_i,
    input  fdtd_word_t        rd_base_i,
    input  logic [SIZE_W-1:0] rd_count_i,
    input  logic              rd_is_ez_i,
    output logic              rd_done_o,

    output logic              rd_req_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  logic              rd_gnt_i,
    input  logic              rd_valid_i,
    input  logic [DATA_W-1:0] rd_data_i,

    output logic [DATA_W-1:0] hy_old_o,
    output logic              hy_old_valid_o,
    output logic [DATA_W-1:0] ez_old_o,
    output logic              ez_old_valid_o
);

    localparam int CNT_W = $clog2(BLOCK_WORDS + 1);
    localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

    logic             active_q;
    logic             is_ez_q;
    fdtd_word_t       base_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] issued_q;
    logic [CNT_W-1:0] returned_q;
    logic [OUT_W-1:0] outst_q;
    logic             rd_grant;
    logic             rd_ret;
    fdtd_addr_u       req_addr;

    // outstanding only drops while a request waits, so the request holds
    assign rd_req_o = active_q && (issued_q != count_q)
                      && (outst_q < OUT_W'(MAX_OUTSTANDING));
    assign rd_grant = rd_req_o & rd_gnt_i;
    assign rd_ret   = active_q & rd_valid_i;

    always_comb
    begin
        req_addr.fld.word     = base_q + fdtd_word_t'(issued_q);
        req_addr.fld.byte_off = 2'b00;
    end

    assign rd_addr_o = req_addr.raw;

    always_ff @(posedge ACLK)
    begin
        if (rd_start_i)
        begin
            base_q  <= rd_base_i;
            count_q <= rd_count_i[CNT_W-1:0];
            is_ez_q <= rd_is_ez_i;
        end
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            active_q   <= 1'b0;
            issued_q   <= '0;
            returned_q <= '0;
            rd_done_o  <= 1'b0;
        end
        else
        begin
            rd_done_o <= 1'b0;
            if (rd_start_i)
            begin
                active_q   <= 1'b1;
                issued_q   <= '0;
                returned_q <= '0;
            end
            else
            begin
                if (rd_grant)
                    issued_q <= issued_q + 1'b1;
                if (rd_ret)
                begin
                    returned_q <= returned_q + 1'b1;
                    // last word of the block is back
                    if (returned_q == count_q - 1'b1)
                    begin
                        active_q  <= 1'b0;
                        rd_done_o <= 1'b1;
                    end
                end
            end
        end
    end

    // reads granted but not yet returned
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            outst_q <= '0;
        else if (rd_grant && !rd_ret)
            outst_q <= outst_q + 1'b1;
        else if (!rd_grant && rd_ret)
            outst_q <= outst_q - 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // steer returned words
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            hy_old_valid_o <= 1'b0;
            ez_old_valid_o <= 1'b0;
        end
        else
        begin
            hy_old_valid_o <= rd_ret & ~is_ez_q;
            ez_old_valid_o <= rd_ret & is_ez_q;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (rd_ret && !is_ez_q)
            hy_old_o <= rd_data_i;
        if (rd_ret && is_ez_q)
            ez_old_o <= rd_data_i;
    end

endmodule

/* rtl/fdtd_sweep_seq.sv */
`timescale 1ns/1ps

module fdtd_sweep_seq
    import fdtd_pkg::*;
#(
    parameter int BLOCK_WORDS = 16
)
(
    input  logic              ACLK,
    input  logic              ARESETn,

    input  logic              start_i,
    input  logic              field_sel_i,
    input  logic [SIZE_W-1:0] size_i,
    input  fdtd_addr_u        hy_addr_i,
    input  fdtd_addr_u        ez_addr_i,
    input  logic              ctrl_int_en_i,
    input  logic              cmd_clr_int_i,

    output logic              rd_start_o,
    output fdtd_word_t        rd_base_o,
    output logic [SIZE_W-1:0] rd_count_o,
    output logic              rd_is_ez_o,
    input  logic              rd_done_i,

    output logic              calc_start_o,
    input  logic              calc_done_i,

    output logic              wr_start_o,
    output fdtd_word_t        wr_base_o,
    output logic [SIZE_W-1:0] wr_count_o,
    input  logic              wr_done_i,

    output logic              busy_o,
    output logic              int_pending_o,
    output logic              int_o
);

    fdtd_state_e       state_q;
    fdtd_word_t        hy_base_q;
    fdtd_word_t        ez_base_q;
    logic              field_q;
    logic [SIZE_W-1:0] offset_q;
    logic [SIZE_W-1:0] remain_q;
    logic [SIZE_W-1:0] blk_words;
    fdtd_word_t        tgt_base;
    logic              busy_q;

    // short last block
    assign blk_words = (remain_q < SIZE_W'(BLOCK_WORDS)) ? remain_q : SIZE_W'(BLOCK_WORDS);

    assign rd_is_ez_o = (state_q == READ_EZ);
    assign rd_base_o  = (rd_is_ez_o ? ez_base_q : hy_base_q) + fdtd_word_t'(offset_q);
    assign rd_count_o = blk_words;

    // field_q set means the Ez array is overwritten
    assign tgt_base   = field_q ? ez_base_q : hy_base_q;
    assign wr_base_o  = tgt_base + fdtd_word_t'(offset_q);
    assign wr_count_o = blk_words;

    assign busy_o = (state_q != IDLE);

    always_ff @(posedge ACLK)
    begin
        if (state_q == IDLE && start_i)
        begin
            hy_base_q <= hy_addr_i.fld.word;
            ez_base_q <= ez_addr_i.fld.word;
            field_q   <= field_sel_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sweep FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state_q      <= IDLE;
            offset_q     <= '0;
            remain_q     <= '0;
            rd_start_o   <= 1'b0;
            calc_start_o <= 1'b0;
            wr_start_o   <= 1'b0;
        end
        else
        begin
            rd_start_o   <= 1'b0;
            calc_start_o <= 1'b0;
            wr_start_o   <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    if (start_i)
                    begin
                        offset_q <= '0;
                        remain_q <= size_i;
                        if (size_i == '0)
                        begin
                            state_q <= NEXT;
                        end
                        else
                        begin
                            state_q    <= READ_HY;
                            rd_start_o <= 1'b1;
                        end
                    end
                end
                READ_HY:
                begin
                    if (rd_done_i)
                    begin
                        state_q    <= READ_EZ;
                        rd_start_o <= 1'b1;
                    end
                end
                READ_EZ:
                begin
                    if (rd_done_i)
                    begin
                        state_q      <= CALC;
                        calc_start_o <= 1'b1;
                    end
                end
                CALC:
                begin
                    state_q <= WAIT_CALC;
                end
                WAIT_CALC:
                begin
                    if (calc_done_i)
                    begin
                        state_q    <= WRITE;
                        wr_start_o <= 1'b1;
                    end
                end
                WRITE:
                begin
                    if (wr_done_i)
                    begin
                        state_q  <= NEXT;
                        offset_q <= offset_q + blk_words;
                        remain_q <= remain_q - blk_words;
                    end
                end
                NEXT:
                begin
                    if (remain_q != '0)
                    begin
                        state_q    <= READ_HY;
                        rd_start_o <= 1'b1;
                    end
                    else
                    begin
                        state_q <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // completion interrupt
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q        <= 1'b0;
            int_pending_o <= 1'b0;
        end
        else
        begin
            busy_q <= busy_o;
            if (cmd_clr_int_i)
                int_pending_o <= 1'b0;
            else if (busy_q && !busy_o)
                int_pending_o <= 1'b1;
        end
    end

    assign int_o = int_pending_o & ctrl_int_en_i;

endmodule

/* rtl/fdtd_wr_engine.sv */
`timescale 1ns/1ps

module fdtd_wr_engine
    import fdtd_pkg::*;
#(
    parameter int BLOCK_WORDS = 16
)
(
    input  logic              ACLK,
    input  logic              ARESETn,

    input  logic              wr_start_i,
    input  fdtd_word_t        wr_base_i,
    input  logic [SIZE_W-1:0] wr_count_i,
    output logic              wr_done_o,

    output logic              wr_req_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [DATA_W-1:0] wr_data_o,
    input  logic              wr_gnt_i,

    input  logic [DATA_W-1:0] new_word_i,
    output logic              new_pop_o
);

    localparam int CNT_W = $clog2(BLOCK_WORDS + 1);

    fdtd_word_t       base_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] idx_q;
    logic             req_q;
    logic             load_q;
    logic             wr_grant;
    fdtd_addr_u       wr_addr;

    assign wr_req_o  = req_q;
    assign wr_grant  = req_q & wr_gnt_i;
    // update engine steps to the next word after this
    assign new_pop_o = wr_grant;

    always_comb
    begin
        wr_addr.fld.word     = base_q + fdtd_word_t'(idx_q);
        wr_addr.fld.byte_off = 2'b00;
    end

    assign wr_addr_o = wr_addr.raw;

    always_ff @(posedge ACLK)
    begin
        if (wr_start_i)
        begin
            base_q  <= wr_base_i;
            count_q <= wr_count_i[CNT_W-1:0];
        end
        // next word shows up the cycle after the pop
        if (wr_start_i || load_q)
            wr_data_o <= new_word_i;
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            req_q     <= 1'b0;
            load_q    <= 1'b0;
            idx_q     <= '0;
            wr_done_o <= 1'b0;
        end
        else
        begin
            wr_done_o <= 1'b0;
            if (wr_start_i)
            begin
                req_q  <= 1'b1;
                load_q <= 1'b0;
                idx_q  <= '0;
            end
            else if (wr_grant)
            begin
                req_q <= 1'b0;
                idx_q <= idx_q + 1'b1;
                if (idx_q == count_q - 1'b1)
                    wr_done_o <= 1'b1;
                else
                    load_q <= 1'b1;
            end
            else if (load_q)
            begin
                load_q <= 1'b0;
                req_q  <= 1'b1;
            end
        end
    end

endmodule

/* tb.f */
+incdir+include
rtl/fdtd_pkg.sv
rtl/fdtd_rd_engine.sv
rtl/fdtd_sweep_seq.sv
rtl/fdtd_wr_engine.sv
rtl/fdtd_mem_ctrl.sv
testbench/tb_fdtd_mem_ctrl.sv

/* include/fdtd_tb_tasks.svh */
`ifndef FDTD_TB_TASKS_SVH
`define FDTD_TB_TASKS_SVH

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_q = lfsr_next(lfsr_q);
        v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
endfunction

task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("error %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_count(input string name, input logic [SIZE_W-1:0] exp,
                           input logic [SIZE_W-1:0] act);
    chk_cnt++;
    if (act !== exp)
    begin
        err_cnt++;
        $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic report_fault(input string msg);
    fault_cnt++;
    $display("%s", msg);
endtask

// streamed words of one block against memory before the sweep
task automatic score_block();
    fdtd_state_e phase;
    string       hy_tag;
    string       ez_tag;
    int          n;
    n = cur_size - blk_off;
    if (n > BLOCK_WORDS)
        n = BLOCK_WORDS;
    phase  = READ_HY;
    hy_tag = $sformatf("%s %s blk %0d", cur_test, phase.name(), blk_num);
    phase  = READ_EZ;
    ez_tag = $sformatf("%s %s blk %0d", cur_test, phase.name(), blk_num);
    check_count({hy_tag, " valids"}, SIZE_W'(n), SIZE_W'(hy_q.size()));
    check_count({ez_tag, " valids"}, SIZE_W'(n), SIZE_W'(ez_q.size()));
    new_q.delete();
    for (int k = 0; k < n; k++)
    begin
        if (k < hy_q.size() && k < ez_q.size())
        begin
            check_word($sformatf("%s word %0d", hy_tag, k),
                       old_mem[hy_word + blk_off + k], hy_q[k]);
            check_word($sformatf("%s word %0d", ez_tag, k),
                       old_mem[ez_word + blk_off + k], ez_q[k]);
            new_q.push_back(hy_q[k] + ez_q[k]);
        end
    end
    hy_q.delete();
    ez_q.delete();
    blk_off += n;
    blk_num++;
endtask

task automatic expect_idle_outputs();
    check_bit("reset rd_req_o", 1'b0, rd_req_o);
    check_bit("reset wr_req_o", 1'b0, wr_req_o);
    check_bit("reset calc_start_o", 1'b0, calc_start_o);
    check_bit("reset new_pop_o", 1'b0, new_pop_o);
    check_bit("reset busy_o", 1'b0, busy_o);
    check_bit("reset int_pending_o", 1'b0, int_pending_o);
    check_bit("reset int_o", 1'b0, int_o);
    check_bit("reset hy_old_valid_o", 1'b0, hy_old_valid_o);
    check_bit("reset ez_old_valid_o", 1'b0, ez_old_valid_o);
endtask

////////////////////////////////////////////////////////////////////////////
// one sweep, from start to the pending interrupt
////////////////////////////////////////////////////////////////////////////
task automatic run_sweep(input string name, input int size, input logic field,
                         input int hy_w, input int ez_w, input logic restart);
    logic [DATA_W-1:0] exp_mem [MEM_WORDS];
    int                tgt_w;
    old_mem = mem;
    exp_mem = mem;
    tgt_w   = field ? ez_w : hy_w;
    for (int k = 0; k < size; k++)
        exp_mem[tgt_w + k] = old_mem[hy_w + k] + old_mem[ez_w + k];
    cur_test   = name;
    cur_size   = size;
    hy_word    = hy_w;
    ez_word    = ez_w;
    blk_off    = 0;
    blk_num    = 0;
    wr_cnt     = 0;
    req_cycles = 0;
    @(posedge ACLK);
    start_i       <= 1'b1;
    size_i        <= SIZE_W'(size);
    field_sel_i   <= field;
    hy_addr_i.raw <= ADDR_W'(hy_w * 4);
    ez_addr_i.raw <= ADDR_W'(ez_w * 4);
    @(posedge ACLK);
    start_i <= 1'b0;
    @(negedge ACLK);
    check_bit({name, " busy rise"}, 1'b1, busy_o);
    if (restart)
    begin
        // a second start with other settings while busy
        repeat (3) @(posedge ACLK);
        start_i     <= 1'b1;
        size_i      <= SIZE_W'(size + 9);
        field_sel_i <= ~field;
        @(posedge ACLK);
        start_i <= 1'b0;
        @(negedge ACLK);
        check_bit({name, " busy at second start"}, 1'b1, busy_o);
    end
    while (busy_o)
        @(negedge ACLK);
    check_count({name, " write grants"}, SIZE_W'(size), SIZE_W'(wr_cnt));
    check_count({name, " blocks"}, SIZE_W'((size + BLOCK_WORDS - 1) / BLOCK_WORDS),
                SIZE_W'(blk_num));
    check_bit({name, " pending at busy fall"}, 1'b0, int_pending_o);
    @(negedge ACLK);
    check_bit({name, " pending"}, 1'b1, int_pending_o);
    for (int i = 0; i < MEM_WORDS; i++)
        check_word($sformatf("%s mem[%0d]", name, i), exp_mem[i], mem[i]);
endtask

task automatic clear_int(input string name);
    @(posedge ACLK);
    cmd_clr_int_i <= 1'b1;
    @(posedge ACLK);
    cmd_clr_int_i <= 1'b0;
    @(negedge ACLK);
    check_bit({name, " pending cleared"}, 1'b0, int_pending_o);
    check_bit({name, " int_o cleared"}, 1'b0, int_o);
endtask

task automatic test_ez_single();
    run_sweep("ez_single", 5, 1'b1, 16, 96, 1'b0);
    clear_int("ez_single");
endtask

task automatic test_hy_multi();
    run_sweep("hy_multi", 2 * BLOCK_WORDS + 3, 1'b0, 16, 96, 1'b0);
    clear_int("hy_multi");
endtask

task automatic test_interrupt();
    @(posedge ACLK);
    ctrl_int_en_i <= 1'b0;
    run_sweep("int_restart", 7, 1'b1, 40, 120, 1'b1);
    check_bit("int_restart int_o masked", 1'b0, int_o);
    @(posedge ACLK);
    ctrl_int_en_i <= 1'b1;
    @(negedge ACLK);
    check_bit("int_restart int_o enabled", 1'b1, int_o);
    clear_int("int_restart");
endtask

task automatic test_size_zero();
    run_sweep("size_zero", 0, 1'b0, 16, 96, 1'b0);
    check_count("size_zero request cycles", '0, SIZE_W'(req_cycles));
    check_bit("size_zero int_o", 1'b1, int_o);
    clear_int("size_zero");
endtask

`endif

/* testbench/tb_fdtd_mem_ctrl.sv */
`timescale 1ns/1ps

module tb_fdtd_mem_ctrl
    import fdtd_pkg::*;
();

    localparam int BLOCK_WORDS     = 16;
    localparam int MAX_OUTSTANDING = 4;
    localparam int MEM_WORDS       = 256;
    localparam logic [31:0] LFSR_SEED = 32'h67f1;
    // word counts of the four sweeps, 40 cycles per word plus slack
    localparam int TEST_WORDS      = 5 + (2 * BLOCK_WORDS + 3) + 7 + 0;
    localparam int TIMEOUT_CYCLES  = TEST_WORDS * 40 + 2000;

    logic              ACLK;
    logic              ARESETn;
    logic              start_i;
    logic              field_sel_i;
    logic [SIZE_W-1:0] size_i;
    fdtd_addr_u        hy_addr_i;
    fdtd_addr_u        ez_addr_i;
    logic              ctrl_int_en_i;
    logic              cmd_clr_int_i;
    logic              rd_req_o;
    logic [ADDR_W-1:0] rd_addr_o;
    logic              rd_gnt_i    = 1'b0;
    logic              rd_valid_i  = 1'b0;
    logic [DATA_W-1:0] rd_data_i   = '0;
    logic              wr_req_o;
    logic [ADDR_W-1:0] wr_addr_o;
    logic [DATA_W-1:0] wr_data_o;
    logic              wr_gnt_i    = 1'b0;
    logic [DATA_W-1:0] hy_old_o;
    logic [DATA_W-1:0] ez_old_o;
    logic              hy_old_valid_o;
    logic              ez_old_valid_o;
    logic              calc_start_o;
    logic              calc_done_i = 1'b0;
    logic [DATA_W-1:0] new_word_i  = '0;
    logic              new_pop_o;
    logic              busy_o;
    logic              int_pending_o;
    logic              int_o;

    // memory and update engine model state
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] old_mem [MEM_WORDS];
    logic [DATA_W-1:0] rd_data_q [$];
    int                rd_due_q [$];
    logic [DATA_W-1:0] hy_q [$];
    logic [DATA_W-1:0] ez_q [$];
    logic [DATA_W-1:0] new_q [$];
    logic [31:0]       lfsr_q = LFSR_SEED;
    int                mem_cyc;
    int                inflight;
    int                rd_wait;
    int                wr_wait;
    int                calc_wait;
    int                new_idx;

    // per sweep bookkeeping
    string             cur_test = "reset";
    int                cur_size;
    int                hy_word;
    int                ez_word;
    int                blk_off;
    int                blk_num;
    int                wr_cnt;
    int                req_cycles;
    int                cycles    = 0;
    int                chk_cnt   = 0;
    int                err_cnt   = 0;
    int                fault_cnt = 0;

    `include "fdtd_tb_tasks.svh"

    fdtd_mem_ctrl #(
        .BLOCK_WORDS     ( BLOCK_WORDS     ),
        .MAX_OUTSTANDING ( MAX_OUTSTANDING )
    ) u_dut (
        .ACLK           ( ACLK           ),
        .ARESETn        ( ARESETn        ),
        .start_i        ( start_i        ),
        .field_sel_i    ( field_sel_i    ),
        .size_i         ( size_i         ),
        .hy_addr_i      ( hy_addr_i      ),
        .ez_addr_i      ( ez_addr_i      ),
        .ctrl_int_en_i  ( ctrl_int_en_i  ),
        .cmd_clr_int_i  ( cmd_clr_int_i  ),
        .rd_req_o       ( rd_req_o       ),
        .rd_addr_o      ( rd_addr_o      ),
        .rd_gnt_i       ( rd_gnt_i       ),
        .rd_valid_i     ( rd_valid_i     ),
        .rd_data_i      ( rd_data_i      ),
        .wr_req_o       ( wr_req_o       ),
        .wr_addr_o      ( wr_addr_o      ),
        .wr_data_o      ( wr_data_o      ),
        .wr_gnt_i       ( wr_gnt_i       ),
        .hy_old_o       ( hy_old_o       ),
        .ez_old_o       ( ez_old_o       ),
        .hy_old_valid_o ( hy_old_valid_o ),
        .ez_old_valid_o ( ez_old_valid_o ),
        .calc_start_o   ( calc_start_o   ),
        .calc_done_i    ( calc_done_i    ),
        .new_word_i     ( new_word_i     ),
        .new_pop_o      ( new_pop_o      ),
        .busy_o         ( busy_o         ),
        .int_pending_o  ( int_pending_o  ),
        .int_o          ( int_o          )
    );

    initial
    begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory and update engine models
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge ACLK)
    begin
        int idx;
        int due;
        if (!ARESETn)
        begin
            rd_gnt_i    <= 1'b0;
            rd_valid_i  <= 1'b0;
            wr_gnt_i    <= 1'b0;
            calc_done_i <= 1'b0;
            rd_data_q.delete();
            rd_due_q.delete();
            mem_cyc   = 0;
            inflight  = 0;
            calc_wait = 0;
            rd_wait   = rand_bits(2);
            wr_wait   = rand_bits(2);
        end
        else
        begin
            mem_cyc++;
            if (rd_req_o || wr_req_o)
                req_cycles++;
            // read port, grant after 0 to 3 cycles
            if (rd_valid_i)
                inflight--;
            if (rd_req_o && rd_gnt_i)
            begin
                idx = int'(rd_addr_o[ADDR_W-1:2]);
                if (idx >= MEM_WORDS)
                    report_fault($sformatf("read outside memory at %h", rd_addr_o));
                due = mem_cyc + 1 + rand_bits(2);
                if (rd_due_q.size() > 0 && due <= rd_due_q[$])
                    due = rd_due_q[$] + 1;
                rd_data_q.push_back(mem[idx % MEM_WORDS]);
                rd_due_q.push_back(due);
                inflight++;
                if (inflight > MAX_OUTSTANDING)
                    report_fault($sformatf("%0d reads in flight, more than the limit of %0d",
                                           inflight, MAX_OUTSTANDING));
                // zero delay keeps the grant up for back to back reads
                rd_wait = rand_bits(2);
                rd_gnt_i <= (rd_wait == 0);
            end
            else if (rd_req_o)
            begin
                if (rd_wait == 0)
                    rd_gnt_i <= 1'b1;
                else
                    rd_wait--;
            end
            // in-order return, one word per cycle
            if (rd_due_q.size() > 0 && rd_due_q[0] <= mem_cyc)
            begin
                rd_valid_i <= 1'b1;
                rd_data_i  <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
            else
            begin
                rd_valid_i <= 1'b0;
            end
            // write port
            if (wr_req_o && wr_gnt_i)
            begin
                idx = int'(wr_addr_o[ADDR_W-1:2]);
                if (idx >= MEM_WORDS)
                    report_fault($sformatf("write outside memory at %h", wr_addr_o));
                else
                    mem[idx] = wr_data_o;
                wr_cnt++;
                wr_gnt_i <= 1'b0;
                wr_wait = rand_bits(2);
            end
            else if (wr_req_o)
            begin
                if (wr_wait == 0)
                    wr_gnt_i <= 1'b1;
                else
                    wr_wait--;
            end
            // update engine
            calc_done_i <= 1'b0;
            if (hy_old_valid_o)
                hy_q.push_back(hy_old_o);
            if (ez_old_valid_o)
                ez_q.push_back(ez_old_o);
            if (calc_start_o)
            begin
                score_block();
                calc_wait = 1 + rand_bits(3);
            end
            else if (calc_wait > 0)
            begin
                calc_wait--;
                if (calc_wait == 0)
                begin
                    calc_done_i <= 1'b1;
                    new_idx = 0;
                    if (new_q.size() > 0)
                        new_word_i <= new_q[0];
                end
            end
            if (new_pop_o)
            begin
                new_idx++;
                if (new_idx < new_q.size())
                    new_word_i <= new_q[new_idx];
            end
        end
    end

    // watchdog
    always @(posedge ACLK)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        start_i       = 1'b0;
        field_sel_i   = 1'b0;
        size_i        = '0;
        hy_addr_i     = '0;
        ez_addr_i     = '0;
        ctrl_int_en_i = 1'b0;
        cmd_clr_int_i = 1'b0;
        ARESETn       = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h5a00_0000 ^ (DATA_W'(i) * 32'h0001_0003);
        repeat (3) @(posedge ACLK);
        ARESETn <= 1'b1;
        @(negedge ACLK);
        expect_idle_outputs();
        test_ez_single();
        test_hy_multi();
        test_interrupt();
        test_size_zero();
        $display("checks %0d, value errors %0d, other errors %0d",
                 chk_cnt, err_cnt, fault_cnt);
        if (err_cnt == 0 && fault_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
